/* qla_bus_pkg.sv */
package qla_bus_pkg;

    // --------------------
    // bus widths
    // --------------------
    // address layout
    //   [15:12] space | [11:8] unused | [7:4] channel | [3:0] offset
    typedef logic [15:0] addr_t;     // register address
    typedef logic [31:0] data_t;     // register data
    typedef logic [3:0]  space_t;    // address bits 15..12
    typedef logic [3:0]  chan_t;     // address bits 7..4
    typedef logic [3:0]  off_t;      // address bits 3..0
    typedef logic [2:0]  rt_addr_t;  // real-time write word index

    // --------------------
    // address spaces
    // --------------------
    localparam space_t ADDR_MAIN = 4'h0;  // main board space

    // --------------------
    // channel offsets
    // --------------------
    // channel 0 holds the global registers, channels 1..4 the axes
    localparam off_t OFF_STATUS   = 4'd0;  // board status, channel 0 only
    localparam off_t OFF_ADC_DATA = 4'd1;  // pot in upper half, cur in lower
    localparam off_t OFF_DAC_CTRL = 4'd2;  // commanded current

endpackage

/* qla_axis_pkg.sv */
package qla_axis_pkg;

    // --------------------
    // axis count and words
    // --------------------
    localparam int NUM_CHANNELS = 4;

    // current/pot word, offset binary around midscale
    typedef logic [15:0] cur_t;
    localparam cur_t CUR_MIDSCALE = 16'h8000;

    // per-axis mask, bit n-1 is axis n
    typedef logic [NUM_CHANNELS-1:0] amp_mask_t;

    // --------------------
    // safety limits
    // --------------------
    localparam int SAFETY_SAMPLES = 4;               // over-limit run that trips
    localparam logic [15:0] SAFETY_MARGIN = 16'h0100; // added to 2x command

    // run counter, counts up to SAFETY_SAMPLES-1 before the trip
    typedef logic [$clog2(SAFETY_SAMPLES)-1:0] run_cnt_t;

    // real-time block writer
    typedef enum logic {
        IDLE,   // waiting for word 4
        BURST   // driving the dac block write
    } bw_state_t;

endpackage

/* write_bus_master.sv */
`timescale 1ns/1ns

module write_bus_master (
    input  logic                  sysclk,
    input  logic                  rst,
    // firewire write bus
    input  logic                  fw_reg_wen,
    input  logic                  fw_blk_wen,
    input  logic                  fw_blk_wstart,
    input  qla_bus_pkg::addr_t    fw_reg_waddr,
    input  qla_bus_pkg::data_t    fw_reg_wdata,
    // ethernet write bus
    input  logic                  eth_reg_wen,
    input  logic                  eth_blk_wen,
    input  logic                  eth_blk_wstart,
    input  qla_bus_pkg::addr_t    eth_reg_waddr,
    input  qla_bus_pkg::data_t    eth_reg_wdata,
    input  logic                  eth_write_en,   // ethernet claims the bus
    // real-time write words
    input  logic                  fw_rt_wen,
    input  qla_bus_pkg::rt_addr_t fw_rt_waddr,
    input  qla_bus_pkg::data_t    fw_rt_wdata,
    input  logic                  eth_rt_wen,
    input  qla_bus_pkg::rt_addr_t eth_rt_waddr,
    input  qla_bus_pkg::data_t    eth_rt_wdata,
    // merged write bus
    output logic                  reg_wen,
    output logic                  blk_wen,
    output logic                  blk_wstart,
    output qla_bus_pkg::addr_t    reg_waddr,
    output qla_bus_pkg::data_t    reg_wdata
);
    import qla_bus_pkg::*;
    import qla_axis_pkg::*;

    logic      rt_wen;
    rt_addr_t  rt_waddr;
    data_t     rt_wdata;
    logic      rt_accept;      // rt word taken, only while idle
    bw_state_t state;
    chan_t     bw_chan;        // channel being written in the burst
    cur_t      rt_cmd [1:NUM_CHANNELS];
    cur_t      bw_cmd;
    logic      bw_write_en;    // burst owns the bus

    // --------------------
    // real-time word merge
    // --------------------
    assign rt_wen   = eth_rt_wen | fw_rt_wen;
    assign rt_waddr = eth_rt_wen ? eth_rt_waddr : fw_rt_waddr;  // eth wins a tie
    assign rt_wdata = eth_rt_wen ? eth_rt_wdata : fw_rt_wdata;

    assign rt_accept = rt_wen && (state == IDLE);  // ignored mid-burst

    // words 1..4 hold the axis commands
    always_ff @(posedge sysclk) begin
        for (int i = 1; i <= NUM_CHANNELS; i++) begin
            if (rt_accept && (rt_waddr == rt_addr_t'(i))) begin
                rt_cmd[i] <= rt_wdata[15:0];
            end
        end
    end

    // --------------------
    // burst FSM
    // --------------------
    // last word kicks off one write per channel, back to back
    always_ff @(posedge sysclk) begin
        if (rst) begin
            state   <= IDLE;
            bw_chan <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (rt_accept && (rt_waddr == rt_addr_t'(NUM_CHANNELS))) begin
                        state   <= BURST;
                        bw_chan <= chan_t'(1);
                    end
                end
                BURST: begin
                    if (bw_chan == chan_t'(NUM_CHANNELS)) begin
                        state   <= IDLE;    // last channel written
                        bw_chan <= '0;
                    end else begin
                        bw_chan <= bw_chan + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign bw_write_en = (state == BURST);

    // pick the stored word for the current channel
    always_comb begin
        bw_cmd = CUR_MIDSCALE;
        for (int i = 1; i <= NUM_CHANNELS; i++) begin
            if (bw_chan == chan_t'(i)) begin
                bw_cmd = rt_cmd[i];
            end
        end
    end

    // write bus priority: burst, then eth, then fw
    always_comb begin
        if (bw_write_en) begin
            reg_wen    = 1'b1;
            blk_wen    = 1'b1;
            blk_wstart = (bw_chan == chan_t'(1));  // first word only
            reg_waddr  = {ADDR_MAIN, 4'd0, bw_chan, OFF_DAC_CTRL};
            reg_wdata  = {16'd0, bw_cmd};
        end else if (eth_write_en) begin
            reg_wen    = eth_reg_wen;
            blk_wen    = eth_blk_wen;
            blk_wstart = eth_blk_wstart;
            reg_waddr  = eth_reg_waddr;
            reg_wdata  = eth_reg_wdata;
        end else begin
            reg_wen    = fw_reg_wen;     // default owner
            blk_wen    = fw_blk_wen;
            blk_wstart = fw_blk_wstart;
            reg_waddr  = fw_reg_waddr;
            reg_wdata  = fw_reg_wdata;
        end
    end

endmodule

/* axis_cmd_regs.sv */
`timescale 1ns/1ns

module axis_cmd_regs (
    input  logic                    sysclk,
    input  logic                    rst,
    input  logic                    reg_wen,
    input  logic                    blk_wen,
    input  qla_bus_pkg::addr_t      reg_waddr,
    input  qla_bus_pkg::data_t      reg_wdata,
    input  logic                    dac_busy,   // dac still shifting out
    output qla_axis_pkg::cur_t      cur_cmd [1:qla_axis_pkg::NUM_CHANNELS],
    output logic                    dac_update,
    output qla_axis_pkg::amp_mask_t amp_enable_cmd
);
    import qla_bus_pkg::*;
    import qla_axis_pkg::*;

    space_t wr_space;
    chan_t  wr_chan;
    off_t   wr_off;
    logic   dac_wr;        // write to some axis dac register
    logic   status_wr;     // write to board status
    logic   cur_cmd_req;   // block written, dac not yet told

    // --------------------
    // write decode
    // --------------------
    assign wr_space = reg_waddr[15:12];
    assign wr_chan  = reg_waddr[7:4];
    assign wr_off   = reg_waddr[3:0];

    // channel 0 is the global register, never a dac
    assign dac_wr = reg_wen && (wr_space == ADDR_MAIN) && (wr_chan != '0) &&
                    (wr_off == OFF_DAC_CTRL);

    assign status_wr = reg_wen && (wr_space == ADDR_MAIN) && (wr_chan == '0) &&
                       (wr_off == OFF_STATUS);

    // commanded current, parked at zero current
    always_ff @(posedge sysclk) begin
        if (rst) begin
            for (int i = 1; i <= NUM_CHANNELS; i++) begin
                cur_cmd[i] <= CUR_MIDSCALE;
            end
        end else begin
            for (int i = 1; i <= NUM_CHANNELS; i++) begin
                if (dac_wr && (wr_chan == chan_t'(i))) begin
                    cur_cmd[i] <= reg_wdata[15:0];
                end
            end
        end
    end

    // --------------------
    // dac update request
    // --------------------
    // wait for the block to finish and the dac to go idle
    assign dac_update = cur_cmd_req && !dac_busy && !dac_wr;

    always_ff @(posedge sysclk) begin
        if (rst) begin
            cur_cmd_req <= 1'b0;
        end else if (dac_wr && blk_wen) begin
            cur_cmd_req <= 1'b1;
        end else if (dac_update) begin
            cur_cmd_req <= 1'b0;     // one strobe per block
        end
    end

    // amp enable, one pulse per set bit 7..4
    always_ff @(posedge sysclk) begin
        if (rst) begin
            amp_enable_cmd <= '0;
        end else begin
            amp_enable_cmd <= status_wr ? reg_wdata[7:4] : '0;
        end
    end

endmodule

/* safety_check.sv */
`timescale 1ns/1ns

module safety_check (
    input  logic               sysclk,
    input  logic               rst,
    input  logic               cur_ready,      // new feedback sample
    input  qla_axis_pkg::cur_t cur_fb,
    input  qla_axis_pkg::cur_t cur_cmd,
    input  logic               clear_disable,  // amp enable from host
    output logic               amp_disable
);
    import qla_axis_pkg::*;

    logic [15:0] fb_mag;      // |feedback - midscale|
    logic [15:0] cmd_mag;     // |command - midscale|
    logic [17:0] limit;       // 2x command plus margin
    logic        over_limit;
    run_cnt_t    run_cnt;     // consecutive over-limit samples

    assign fb_mag  = (cur_fb >= CUR_MIDSCALE) ? (cur_fb - CUR_MIDSCALE)
                                              : (CUR_MIDSCALE - cur_fb);
    assign cmd_mag = (cur_cmd >= CUR_MIDSCALE) ? (cur_cmd - CUR_MIDSCALE)
                                               : (CUR_MIDSCALE - cur_cmd);

    assign limit      = {1'b0, cmd_mag, 1'b0} + {2'b00, SAFETY_MARGIN};
    assign over_limit = ({2'b00, fb_mag} > limit);

    // sticky until the host re-enables the amp
    always_ff @(posedge sysclk) begin
        if (rst) begin
            run_cnt     <= '0;
            amp_disable <= 1'b0;
        end else if (clear_disable) begin
            run_cnt     <= '0;
            amp_disable <= 1'b0;
        end else if (cur_ready) begin
            if (!over_limit) begin
                run_cnt <= '0;            // run broken
            end else if (run_cnt == run_cnt_t'(SAFETY_SAMPLES - 1)) begin
                amp_disable <= 1'b1;      // trip
            end else begin
                run_cnt <= run_cnt + 1'b1;
            end
        end
    end

endmodule

/* reg_read_mux.sv */
`timescale 1ns/1ns

module reg_read_mux (
    input  qla_bus_pkg::addr_t      reg_raddr,
    input  logic [3:0]              board_id,
    input  qla_axis_pkg::cur_t      cur_fb  [1:qla_axis_pkg::NUM_CHANNELS],
    input  qla_axis_pkg::cur_t      pot_fb  [1:qla_axis_pkg::NUM_CHANNELS],
    input  qla_axis_pkg::cur_t      cur_cmd [1:qla_axis_pkg::NUM_CHANNELS],
    input  qla_axis_pkg::amp_mask_t amp_disable,
    output qla_bus_pkg::data_t      reg_rdata
);
    import qla_bus_pkg::*;
    import qla_axis_pkg::*;

    space_t rd_space;
    chan_t  rd_chan;
    off_t   rd_off;

    assign rd_space = reg_raddr[15:12];
    assign rd_chan  = reg_raddr[7:4];
    assign rd_off   = reg_raddr[3:0];

    // --------------------
    // read decode
    // --------------------
    always_comb begin
        reg_rdata = '0;     // unmapped reads return zero
        if (rd_space == ADDR_MAIN) begin
            if (rd_chan == '0) begin
                // global register, status only
                if (rd_off == OFF_STATUS) begin
                    reg_rdata = {24'd0, amp_disable, board_id};
                end
            end else begin
                for (int i = 1; i <= NUM_CHANNELS; i++) begin
                    if (rd_chan == chan_t'(i)) begin
                        case (rd_off)
                            OFF_ADC_DATA: reg_rdata = {pot_fb[i], cur_fb[i]};
                            OFF_DAC_CTRL: reg_rdata = {16'd0, cur_cmd[i]};
                            default:      reg_rdata = '0;
                        endcase
                    end
                end
            end
        end
    end

endmodule

/* qla_board_bus.sv */
`timescale 1ns/1ns

module qla_board_bus (
    input  logic                    sysclk,
    input  logic                    rst,
    input  logic [3:0]              wenid,          // rotary switch, inverted
    // firewire master
    input  logic                    fw_reg_wen,
    input  logic                    fw_blk_wen,
    input  logic                    fw_blk_wstart,
    input  qla_bus_pkg::addr_t      fw_reg_waddr,
    input  qla_bus_pkg::data_t      fw_reg_wdata,
    input  qla_bus_pkg::addr_t      fw_reg_raddr,
    input  logic                    fw_rt_wen,
    input  qla_bus_pkg::rt_addr_t   fw_rt_waddr,
    input  qla_bus_pkg::data_t      fw_rt_wdata,
    // ethernet master
    input  logic                    eth_reg_wen,
    input  logic                    eth_blk_wen,
    input  logic                    eth_blk_wstart,
    input  qla_bus_pkg::addr_t      eth_reg_waddr,
    input  qla_bus_pkg::data_t      eth_reg_wdata,
    input  logic                    eth_write_en,
    input  logic                    eth_read_en,
    input  qla_bus_pkg::addr_t      eth_reg_raddr,
    input  logic                    eth_rt_wen,
    input  qla_bus_pkg::rt_addr_t   eth_rt_waddr,
    input  qla_bus_pkg::data_t      eth_rt_wdata,
    // adc feedback and dac
    input  logic                    cur_ready,
    input  qla_axis_pkg::cur_t      cur_fb [1:qla_axis_pkg::NUM_CHANNELS],
    input  qla_axis_pkg::cur_t      pot_fb [1:qla_axis_pkg::NUM_CHANNELS],
    input  logic                    dac_busy,
    output qla_bus_pkg::data_t      reg_rdata,
    output qla_axis_pkg::cur_t      cur_cmd [1:qla_axis_pkg::NUM_CHANNELS],
    output logic                    dac_update,
    output qla_axis_pkg::amp_mask_t amp_disable
);
    import qla_bus_pkg::*;
    import qla_axis_pkg::*;

    logic [3:0] board_id;
    addr_t      reg_raddr;
    logic       reg_wen;          // merged write bus
    logic       blk_wen;
    addr_t      reg_waddr;
    data_t      reg_wdata;
    amp_mask_t  amp_enable_cmd;   // host re-enable pulses

    assign board_id  = ~wenid;
    assign reg_raddr = eth_read_en ? eth_reg_raddr : fw_reg_raddr;

    // --------------------
    // write bus
    // --------------------
    write_bus_master i_write_bus_master (
        .sysclk         (sysclk),
        .rst            (rst),
        .fw_reg_wen     (fw_reg_wen),
        .fw_blk_wen     (fw_blk_wen),
        .fw_blk_wstart  (fw_blk_wstart),
        .fw_reg_waddr   (fw_reg_waddr),
        .fw_reg_wdata   (fw_reg_wdata),
        .eth_reg_wen    (eth_reg_wen),
        .eth_blk_wen    (eth_blk_wen),
        .eth_blk_wstart (eth_blk_wstart),
        .eth_reg_waddr  (eth_reg_waddr),
        .eth_reg_wdata  (eth_reg_wdata),
        .eth_write_en   (eth_write_en),
        .fw_rt_wen      (fw_rt_wen),
        .fw_rt_waddr    (fw_rt_waddr),
        .fw_rt_wdata    (fw_rt_wdata),
        .eth_rt_wen     (eth_rt_wen),
        .eth_rt_waddr   (eth_rt_waddr),
        .eth_rt_wdata   (eth_rt_wdata),
        .reg_wen        (reg_wen),
        .blk_wen        (blk_wen),
        .blk_wstart     (),
        .reg_waddr      (reg_waddr),
        .reg_wdata      (reg_wdata)
    );

    axis_cmd_regs i_axis_cmd_regs (
        .sysclk         (sysclk),
        .rst            (rst),
        .reg_wen        (reg_wen),
        .blk_wen        (blk_wen),
        .reg_waddr      (reg_waddr),
        .reg_wdata      (reg_wdata),
        .dac_busy       (dac_busy),
        .cur_cmd        (cur_cmd),
        .dac_update     (dac_update),
        .amp_enable_cmd (amp_enable_cmd)
    );

    // --------------------
    // per-axis safety
    // --------------------
    generate
        for (genvar i = 1; i <= NUM_CHANNELS; i++) begin : g_safety
            safety_check i_safety_check (
                .sysclk        (sysclk),
                .rst           (rst),
                .cur_ready     (cur_ready),
                .cur_fb        (cur_fb[i]),
                .cur_cmd       (cur_cmd[i]),
                .clear_disable (amp_enable_cmd[i-1]),
                .amp_disable   (amp_disable[i-1])   // bit n-1 is axis n
            );
        end
    endgenerate

    // read path, combinational from the address
    reg_read_mux i_reg_read_mux (
        .reg_raddr   (reg_raddr),
        .board_id    (board_id),
        .cur_fb      (cur_fb),
        .pot_fb      (pot_fb),
        .cur_cmd     (cur_cmd),
        .amp_disable (amp_disable),
        .reg_rdata   (reg_rdata)
    );

endmodule

/* tb_qla_board_bus.sv */
`timescale 1ns/1ns

module tb_qla_board_bus;

    logic        sysclk;
    logic        rst;
    logic [3:0]  wenid;
    logic        fw_reg_wen;
    logic        fw_blk_wen;
    logic        fw_blk_wstart;
    logic [15:0] fw_reg_waddr;
    logic [31:0] fw_reg_wdata;
    logic [15:0] fw_reg_raddr;
    logic        fw_rt_wen;
    logic [2:0]  fw_rt_waddr;
    logic [31:0] fw_rt_wdata;
    logic        eth_reg_wen;
    logic        eth_blk_wen;
    logic        eth_blk_wstart;
    logic [15:0] eth_reg_waddr;
    logic [31:0] eth_reg_wdata;
    logic        eth_write_en;
    logic        eth_read_en;
    logic [15:0] eth_reg_raddr;
    logic        eth_rt_wen;
    logic [2:0]  eth_rt_waddr;
    logic [31:0] eth_rt_wdata;
    logic        cur_ready;
    logic [15:0] cur_fb [1:4];
    logic [15:0] pot_fb [1:4];
    logic        dac_busy;
    logic [31:0] reg_rdata;
    logic [15:0] cur_cmd [1:4];
    logic        dac_update;
    logic [3:0]  amp_disable;

    int n_lines;      // golden lines, sizes the watchdog
    int n_checks;
    int n_errors;
    int total_upd;    // dac_update pulses seen so far
    int upd_base;     // pulse count at the last upd check

    qla_board_bus i_qla_board_bus (.*);

    always #10 sysclk = ~sysclk;   // 20 ns period

    // one pulse per cycle where dac_update is high
    always @(posedge sysclk) begin
        if (!rst && dac_update) total_upd <= total_upd + 1;
    end

    // --------------------
    // helpers
    // --------------------
    // through the next rising edge to the falling edge after it
    task automatic next_cycle();
        @(posedge sysclk);
        @(negedge sysclk);
    endtask

    task automatic release_writes();
        fw_reg_wen     = 1'b0;
        fw_blk_wen     = 1'b0;
        fw_blk_wstart  = 1'b0;
        eth_reg_wen    = 1'b0;
        eth_blk_wen    = 1'b0;
        eth_blk_wstart = 1'b0;
        eth_write_en   = 1'b0;
        fw_rt_wen      = 1'b0;
        eth_rt_wen     = 1'b0;
        eth_read_en    = 1'b0;
    endtask

    // one golden operation, fields a b c in hex
    task automatic run_op(input string name, input string op,
                          input logic [31:0] a, input logic [31:0] b, input logic [31:0] c);
        int waited;
        int ch;       // channel field of a read address
        case (op)
            "fw_wr": begin
                fw_reg_waddr  = a[15:0];
                fw_reg_wdata  = b;
                fw_reg_wen    = 1'b1;
                fw_blk_wen    = c[0];
                fw_blk_wstart = c[0];   // single-word block
                next_cycle();
                release_writes();
            end
            "clash": begin              // same address, eth claims the bus
                eth_reg_waddr = a[15:0];
                eth_reg_wdata = b;
                eth_reg_wen   = 1'b1;
                eth_write_en  = 1'b1;
                fw_reg_waddr  = a[15:0];
                fw_reg_wdata  = c;
                fw_reg_wen    = 1'b1;
                next_cycle();
                release_writes();
            end
            "rt": begin
                fw_rt_waddr = a[2:0];
                fw_rt_wdata = b;
                fw_rt_wen   = 1'b1;
                next_cycle();
                release_writes();
            end
            "rt_clash": begin
                eth_rt_waddr = a[2:0];
                eth_rt_wdata = b;
                eth_rt_wen   = 1'b1;
                fw_rt_waddr  = a[2:0];
                fw_rt_wdata  = c;
                fw_rt_wen    = 1'b1;
                next_cycle();
                release_writes();
            end
            "rd": begin
                fw_reg_raddr = a[15:0];
                next_cycle();
                n_checks++;
                if (reg_rdata !== b) begin
                    n_errors++;
                    $display("[FAIL] %s: expected %h, actual %h", name, b, reg_rdata);
                end
                // dac register reads also check the command output
                ch = int'(a[7:4]);
                if (a[15:12] == 4'h0 && a[3:0] == 4'h2 && ch >= 1 && ch <= 4) begin
                    n_checks++;
                    if (cur_cmd[ch] !== b[15:0]) begin
                        n_errors++;
                        $display("[FAIL] %s cur_cmd: expected %h, actual %h", name, b[15:0],
                                 cur_cmd[ch]);
                    end
                end
            end
            "rd_eth": begin             // fw points elsewhere on purpose
                eth_reg_raddr = a[15:0];
                eth_read_en   = 1'b1;
                fw_reg_raddr  = b[15:0];
                next_cycle();
                n_checks++;
                if (reg_rdata !== c) begin
                    n_errors++;
                    $display("[FAIL] %s: expected %h, actual %h", name, c, reg_rdata);
                end
                release_writes();
            end
            "fb": begin
                cur_fb[a[2:0]] = b[15:0];
                pot_fb[a[2:0]] = c[15:0];
                next_cycle();
            end
            "ready": begin              // a consecutive strobes
                cur_ready = 1'b1;
                repeat (a) next_cycle();
                cur_ready = 1'b0;
            end
            "busy": begin
                dac_busy = a[0];
                next_cycle();
            end
            "idle": repeat (a) next_cycle();
            "wait_upd": begin
                waited = 0;
                while (total_upd == upd_base && waited < 100) begin
                    next_cycle();
                    waited++;
                end
                if (total_upd == upd_base) begin
                    n_errors++;
                    $display("%s: no dac_update pulse within 100 cycles", name);
                end
            end
            "upd": begin
                n_checks++;
                if (total_upd - upd_base != int'(a)) begin
                    n_errors++;
                    $display("[FAIL] %s: expected %0d, actual %0d", name, a,
                             total_upd - upd_base);
                end
                upd_base = total_upd;
            end
            "amp": begin
                n_checks++;
                if (amp_disable !== a[3:0]) begin
                    n_errors++;
                    $display("[FAIL] %s: expected %h, actual %h", name, a[3:0], amp_disable);
                end
            end
            default: begin
                n_errors++;
                $display("%s: unknown operation %s in the golden file", name, op);
            end
        endcase
    endtask

    // --------------------
    // main sequence
    // --------------------
    initial begin
        int          fd;
        int          n;
        string       line;
        string       name;
        string       op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;

        sysclk        = 1'b0;
        rst           = 1'b1;
        wenid         = 4'h5;       // board id reads back as a
        fw_reg_waddr  = '0;
        fw_reg_wdata  = '0;
        fw_reg_raddr  = '0;
        fw_rt_waddr   = '0;
        fw_rt_wdata   = '0;
        eth_reg_waddr = '0;
        eth_reg_wdata = '0;
        eth_reg_raddr = '0;
        eth_rt_waddr  = '0;
        eth_rt_wdata  = '0;
        cur_ready     = 1'b0;
        dac_busy      = 1'b0;
        release_writes();
        for (int i = 1; i <= 4; i++) begin
            cur_fb[i] = 16'h8000;   // zero current
            pot_fb[i] = 16'h0000;
        end
        n_checks  = 0;
        n_errors  = 0;
        total_upd = 0;
        upd_base  = 0;

        fd = $fopen("qla_board_bus_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open qla_board_bus_golden.txt");
            $display("Simulation failed");
            $finish;
        end else begin
            n_lines = 0;
            while ($fgets(line, fd) != 0) n_lines++;
            $fclose(fd);

            repeat (10) @(posedge sysclk);
            @(negedge sysclk);
            rst = 1'b0;

            fd = $fopen("qla_board_bus_golden.txt", "r");
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line.getc(0) == "#") continue;   // comment or blank
                n = $sscanf(line, "%s %s %h %h %h", name, op, a, b, c);
                if (n != 5) begin
                    n_errors++;
                    $display("malformed golden line: %s", line);
                end else begin
                    run_op(name, op, a, b, c);
                end
            end
            $fclose(fd);

            $display("checks: %0d, errors: %0d", n_checks, n_errors);
            if (n_errors == 0) begin
                $display("Simulation passed");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

    // watchdog, 200 cycles per golden line
    initial begin
        wait (n_lines > 0);
        repeat (n_lines * 200) @(posedge sysclk);
        $display("timeout: golden sequence did not finish");
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* qla_board_bus_golden.txt */
# name op a b c, numbers in hex, unused fields 0
# fw_wr addr data blk | clash addr eth_data fw_data | rt addr data | rt_clash addr eth fw
# rd addr expect | rd_eth eth_addr fw_addr expect | fb chan cur pot | ready n | busy level
# idle n | wait_upd | upd pulses | amp mask
cmd_ch1     fw_wr    0012 abcd1111 0
cmd_ch2     fw_wr    0022 abcd2222 0
cmd_ch3     fw_wr    0032 abcd3333 0
cmd_ch4     fw_wr    0042 abcd4444 0
cmd_ch0     fw_wr    0002 00009999 0
rb_ch1      rd       0012 00001111 0
rb_ch2      rd       0022 00002222 0
rb_ch3      rd       0032 00003333 0
rb_ch4      rd       0042 00004444 0
rb_ch0      rd       0002 00000000 0
clash_wr    clash    0012 00005aa5 0000a55a
clash_rb    rd       0012 00005aa5 0
rd_eth_sel  rd_eth   0012 0022 00005aa5
rt_w1       rt       1 ffff7001 0
rt_clash    rt_clash 2 00007002 00007ff2
rt_w3       rt       3 00007003 0
rt_w4       rt       4 00007004 0
rt_sync     wait_upd 0 0 0
rt_settle   idle     5 0 0
rt_upd      upd      1 0 0
rt_rb1      rd       0012 00007001 0
rt_rb2      rd       0022 00007002 0
rt_rb3      rd       0032 00007003 0
rt_rb4      rd       0042 00007004 0
busy_on     busy     1 0 0
blk_wr      fw_wr    0012 00008000 1
blk_hold    idle     0a 0 0
blk_none    upd      0 0 0
busy_off    busy     0 0 0
blk_sync    wait_upd 0 0 0
blk_settle  idle     5 0 0
blk_upd     upd      1 0 0
plain_wr    fw_wr    0022 00008000 0
plain_idle  idle     5 0 0
plain_upd   upd      0 0 0
rtb_busy    busy     1 0 0
rtb_w1      rt       1 00008000 0
rtb_w2      rt       2 00008000 0
rtb_w3      rt       3 00008000 0
rtb_w4      rt       4 00008000 0
rtb_hold    idle     0a 0 0
rtb_none    upd      0 0 0
rtb_free    busy     0 0 0
rtb_sync    wait_upd 0 0 0
rtb_settle  idle     5 0 0
rtb_upd     upd      1 0 0
stat_idle   rd       0000 0000000a 0
fb_hi1      fb       1 8200 1234
trip_short  ready    3 0 0
amp_short   amp      0 0 0
trip_last   ready    1 0 0
amp_ax1     amp      1 0 0
stat_ax1    rd       0000 0000001a 0
clr_ax1     fw_wr    0000 00000010 0
clr_wait1   idle     1 0 0
amp_clr1    amp      0 0 0
run_a       ready    2 0 0
fb_ok1      fb       1 8050 1234
run_brk     ready    1 0 0
fb_hi1b     fb       1 8200 1234
run_b       ready    3 0 0
amp_broken  amp      0 0 0
run_c       ready    1 0 0
amp_ax1b    amp      1 0 0
clr_ax1b    fw_wr    0000 00000010 0
clr_wait1b  idle     1 0 0
amp_clr1b   amp      0 0 0
fb_mid1     fb       1 8000 1234
fb_lo3      fb       3 7e00 0000
trip_ax3    ready    4 0 0
amp_ax3     amp      4 0 0
stat_ax3    rd       0000 0000004a 0
clr_ax3     fw_wr    0000 00000040 0
clr_wait3   idle     1 0 0
amp_clr3    amp      0 0 0
stat_clr    rd       0000 0000000a 0
fb_ch2      fb       2 1234 abcd
adc_ch2     rd       0021 abcd1234 0
adc_ch4     rd       0041 00008000 0
adc_gap     rd       0023 00000000 0
adc_ch0     rd       0001 00000000 0
adc_ch5     rd       0052 00000000 0
adc_space   rd       1012 00000000 0

/* qla_board_bus.f */
qla_bus_pkg.sv
qla_axis_pkg.sv
write_bus_master.sv
axis_cmd_regs.sv
safety_check.sv
reg_read_mux.sv
qla_board_bus.sv
tb_qla_board_bus.sv

/* Makefile */
TOP := tb_qla_board_bus

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): $(wildcard *.sv) qla_board_bus.f
	verilator --binary --timing -j 0 -f qla_board_bus.f --top-module $(TOP)

# pass only when the simulation prints the pass line
run: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Simulation passed"

lint:
	verilator --lint-only --timing -f qla_board_bus.f --top-module $(TOP)

clean:
	rm -rf obj_dir
